// ==== rtl/procyon_pkg.sv ====
//==============================
// Widths, depths and encodings shared by the whole core
// ROB_DEPTH must be a power of two because the ROB pointers wrap freely
// Index widths are set by hand and must track the depths
//==============================

package procyon_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int RAT_DEPTH     = 32;
    localparam int RAT_IDX_WIDTH = 5;
    localparam int ROB_DEPTH     = 8;
    localparam int ROB_IDX_WIDTH = 3;
    localparam int RS_DEPTH      = 4;

    typedef logic [DATA_WIDTH-1:0]    word_t;
    typedef logic [RAT_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [ROB_IDX_WIDTH-1:0] rob_tag_t;

    // Major opcodes, insn[6:0]
    typedef enum logic [6:0] {
        PCYN_OPCODE_OP     = 7'b0110011,
        PCYN_OPCODE_OP_IMM = 7'b0010011
    } pcyn_opcode_t;

    typedef enum logic [3:0] {
        PCYN_OP_ADD,
        PCYN_OP_SUB,
        PCYN_OP_AND,
        PCYN_OP_OR,
        PCYN_OP_XOR,
        PCYN_OP_SLL,
        PCYN_OP_SRL,
        PCYN_OP_SRA,
        PCYN_OP_SLT,
        PCYN_OP_SLTU
    } pcyn_op_t;

endpackage

// ==== rtl/procyon_fu_if.sv ====
//==============================
// Issue path from the reservation station to the IEU
// valid is a single-cycle strobe with no back-pressure
//==============================

interface procyon_fu_if;

    logic                  valid;
    procyon_pkg::pcyn_op_t op;
    procyon_pkg::word_t    src_a;
    procyon_pkg::word_t    src_b;
    procyon_pkg::rob_tag_t tag;   // Destination ROB entry

    modport rs  (output valid, op, src_a, src_b, tag);
    modport ieu (input  valid, op, src_a, src_b, tag);

endinterface

// ==== rtl/procyon_decode.sv ====
//==============================
// Purely combinational decode of RV32I OP and OP-IMM
// Other opcodes are not supported and must not be sent
// The immediate is folded into source two for OP-IMM
//==============================

module procyon_decode (
    input  logic                  i_insn_valid,
    input  procyon_pkg::word_t    i_insn,
    input  logic                  i_rob_full,
    input  logic                  i_rs_full,
    output logic                  o_insn_stall,
    output procyon_pkg::reg_idx_t o_lookup_rsrc     [0:1],
    input  logic                  i_rat_rdy         [0:1],
    input  procyon_pkg::word_t    i_rat_data        [0:1],
    input  procyon_pkg::rob_tag_t i_rat_tag         [0:1],
    input  logic                  i_rob_lookup_rdy  [0:1],
    input  procyon_pkg::word_t    i_rob_lookup_data [0:1],
    output logic                  o_dispatch_en,
    output procyon_pkg::pcyn_op_t o_dispatch_op,
    output procyon_pkg::word_t    o_dispatch_imm,
    output procyon_pkg::reg_idx_t o_dispatch_rdst,
    output logic                  o_src_rdy         [0:1],
    output procyon_pkg::word_t    o_src_data        [0:1],
    output procyon_pkg::rob_tag_t o_src_tag         [0:1]
);

    logic [2:0] funct3;
    logic       alt;      // funct7[5], selects SUB and SRA
    logic       is_imm;

    assign funct3 = i_insn[14:12];
    assign alt    = i_insn[30];
    assign is_imm = (i_insn[6:0] == procyon_pkg::PCYN_OPCODE_OP_IMM);

    assign o_insn_stall    = i_rob_full | i_rs_full;
    assign o_dispatch_en   = i_insn_valid & ~o_insn_stall;
    assign o_dispatch_rdst = i_insn[11:7];
    assign o_dispatch_imm  = {{20{i_insn[31]}}, i_insn[31:20]};
    assign o_lookup_rsrc[0] = i_insn[19:15];
    assign o_lookup_rsrc[1] = i_insn[24:20];

    always_comb begin
        case (funct3)
            3'b000:  o_dispatch_op = (alt && !is_imm) ? procyon_pkg::PCYN_OP_SUB : procyon_pkg::PCYN_OP_ADD;
            3'b001:  o_dispatch_op = procyon_pkg::PCYN_OP_SLL;
            3'b010:  o_dispatch_op = procyon_pkg::PCYN_OP_SLT;
            3'b011:  o_dispatch_op = procyon_pkg::PCYN_OP_SLTU;
            3'b100:  o_dispatch_op = procyon_pkg::PCYN_OP_XOR;
            3'b101:  o_dispatch_op = alt ? procyon_pkg::PCYN_OP_SRA : procyon_pkg::PCYN_OP_SRL;
            3'b110:  o_dispatch_op = procyon_pkg::PCYN_OP_OR;
            default: o_dispatch_op = procyon_pkg::PCYN_OP_AND;
        endcase
    end

    // Committed value first, then a finished but unretired producer, else wait on the tag
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_src_rdy[i]  = i_rat_rdy[i] | i_rob_lookup_rdy[i];
            o_src_data[i] = i_rat_rdy[i] ? i_rat_data[i] : i_rob_lookup_data[i];
            o_src_tag[i]  = i_rat_tag[i];
        end

        if (is_imm) begin
            o_src_rdy[1]  = 1'b1;
            o_src_data[1] = o_dispatch_imm;
        end
    end

    always_comb begin
        if (o_dispatch_en) begin
            assert final (i_insn[6:0] inside {procyon_pkg::PCYN_OPCODE_OP,
                                              procyon_pkg::PCYN_OPCODE_OP_IMM})
                else $error("unsupported opcode %b accepted", i_insn[6:0]);
        end
    end

endmodule

// ==== rtl/procyon_rat.sv ====
//==============================
// Register alias table
// x0 is never renamed or written so it always reads ready with 0
// A rename in the same cycle as a retire to that register wins
//==============================

module procyon_rat (
    input  logic                  clk,
    input  logic                  i_rst,
    input  procyon_pkg::reg_idx_t i_lookup_rsrc [0:1],
    output logic                  o_lookup_rdy  [0:1],
    output procyon_pkg::word_t    o_lookup_data [0:1],
    output procyon_pkg::rob_tag_t o_lookup_tag  [0:1],
    input  logic                  i_rename_en,
    input  procyon_pkg::reg_idx_t i_rename_rdst,
    input  procyon_pkg::rob_tag_t i_rename_tag,
    input  logic                  i_retire_en,
    input  procyon_pkg::reg_idx_t i_retire_rdst,
    input  procyon_pkg::word_t    i_retire_data,
    input  procyon_pkg::rob_tag_t i_retire_tag
);

    logic                  rat_rdy  [procyon_pkg::RAT_DEPTH];
    procyon_pkg::word_t    rat_data [procyon_pkg::RAT_DEPTH];
    procyon_pkg::rob_tag_t rat_tag  [procyon_pkg::RAT_DEPTH];   // Newest producer
    logic                  retire_hit;
    logic                  rename_hit;

    // Only the newest producer of a register may commit into it
    assign retire_hit = i_retire_en && (i_retire_rdst != '0) &&
                        (rat_tag[i_retire_rdst] == i_retire_tag);
    assign rename_hit = i_rename_en && (i_rename_rdst != '0);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_lookup_rdy[i]  = rat_rdy[i_lookup_rsrc[i]];
            o_lookup_data[i] = rat_data[i_lookup_rsrc[i]];
            o_lookup_tag[i]  = rat_tag[i_lookup_rsrc[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < procyon_pkg::RAT_DEPTH; i++) begin
                rat_rdy[i]  <= 1'b1;
                rat_data[i] <= '0;
            end
        end else begin
            if (retire_hit) begin
                rat_rdy[i_retire_rdst]  <= 1'b1;
                rat_data[i_retire_rdst] <= i_retire_data;
            end

            if (rename_hit) begin
                rat_rdy[i_rename_rdst] <= 1'b0;
                rat_tag[i_rename_rdst] <= i_rename_tag;
            end
        end
    end

endmodule

// ==== rtl/procyon_rob.sv ====
//==============================
// Reorder buffer, circular with head and tail pointers
// The new tag is the tail and is valid in the reserve cycle
// Retire is combinational from the head entry, one per cycle
//==============================

module procyon_rob (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_reserve_en,
    input  procyon_pkg::reg_idx_t i_reserve_rdst,
    output procyon_pkg::rob_tag_t o_reserve_tag,
    output logic                  o_rob_full,
    input  procyon_pkg::rob_tag_t i_lookup_tag  [0:1],
    output logic                  o_lookup_rdy  [0:1],
    output procyon_pkg::word_t    o_lookup_data [0:1],
    input  logic                  i_cdb_en,
    input  procyon_pkg::word_t    i_cdb_data,
    input  procyon_pkg::rob_tag_t i_cdb_tag,
    output logic                  o_retire_en,
    output procyon_pkg::reg_idx_t o_retire_rdst,
    output procyon_pkg::word_t    o_retire_data,
    output procyon_pkg::rob_tag_t o_retire_tag
);

    logic                  rob_valid [procyon_pkg::ROB_DEPTH];
    logic                  rob_rdy   [procyon_pkg::ROB_DEPTH];
    procyon_pkg::reg_idx_t rob_rdst  [procyon_pkg::ROB_DEPTH];
    procyon_pkg::word_t    rob_data  [procyon_pkg::ROB_DEPTH];
    procyon_pkg::rob_tag_t head;
    procyon_pkg::rob_tag_t tail;
    logic [procyon_pkg::ROB_IDX_WIDTH:0] count;   // One extra bit to tell full from empty

    assign o_reserve_tag = tail;
    assign o_rob_full    = (count == procyon_pkg::ROB_DEPTH);

    assign o_retire_en   = rob_valid[head] && rob_rdy[head];
    assign o_retire_rdst = rob_rdst[head];
    assign o_retire_data = rob_data[head];
    assign o_retire_tag  = head;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            o_lookup_rdy[i]  = rob_rdy[i_lookup_tag[i]];
            o_lookup_data[i] = rob_data[i_lookup_tag[i]];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < procyon_pkg::ROB_DEPTH; i++) begin
                rob_valid[i] <= 1'b0;
            end
        end else begin
            if (i_reserve_en) begin
                rob_valid[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end

            if (o_retire_en) begin
                rob_valid[head] <= 1'b0;
                head            <= head + 1'b1;
            end

            count <= count + (procyon_pkg::ROB_IDX_WIDTH + 1)'(i_reserve_en)
                           - (procyon_pkg::ROB_IDX_WIDTH + 1)'(o_retire_en);
        end
    end

    // Tail and CDB tag never name the same entry
    always_ff @(posedge clk) begin
        if (i_reserve_en) begin
            rob_rdy[tail]  <= 1'b0;
            rob_rdst[tail] <= i_reserve_rdst;
        end

        if (i_cdb_en) begin
            rob_rdy[i_cdb_tag]  <= 1'b1;
            rob_data[i_cdb_tag] <= i_cdb_data;
        end
    end

    a_no_reserve_when_full: assert property (@(posedge clk) disable iff (i_rst)
        i_reserve_en |-> !o_rob_full);

    // A result must belong to a live entry still waiting on it
    a_cdb_hits_waiting_entry: assert property (@(posedge clk) disable iff (i_rst)
        i_cdb_en |-> rob_valid[i_cdb_tag] && !rob_rdy[i_cdb_tag]);

endmodule

// ==== rtl/procyon_rs.sv ====
//==============================
// Integer reservation station
// Issue is combinational from stored state so a new entry waits one cycle
// Oldest ready entry wins, tracked with a per-entry mask of older entries
//==============================

module procyon_rs (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_reserve_en,
    input  procyon_pkg::pcyn_op_t i_op,
    input  procyon_pkg::rob_tag_t i_dst_tag,
    input  logic                  i_src_rdy  [0:1],
    input  procyon_pkg::word_t    i_src_data [0:1],
    input  procyon_pkg::rob_tag_t i_src_tag  [0:1],
    output logic                  o_rs_full,
    input  logic                  i_cdb_en,
    input  procyon_pkg::word_t    i_cdb_data,
    input  procyon_pkg::rob_tag_t i_cdb_tag,
    procyon_fu_if.rs              fu
);

    logic [procyon_pkg::RS_DEPTH-1:0] rs_valid;
    logic [procyon_pkg::RS_DEPTH-1:0] rs_ready;
    logic [procyon_pkg::RS_DEPTH-1:0] rs_age      [procyon_pkg::RS_DEPTH];   // Older entries
    procyon_pkg::pcyn_op_t            rs_op       [procyon_pkg::RS_DEPTH];
    procyon_pkg::rob_tag_t            rs_dst_tag  [procyon_pkg::RS_DEPTH];
    logic                             rs_src_rdy  [procyon_pkg::RS_DEPTH][2];
    procyon_pkg::word_t               rs_src_data [procyon_pkg::RS_DEPTH][2];
    procyon_pkg::rob_tag_t            rs_src_tag  [procyon_pkg::RS_DEPTH][2];
    logic [procyon_pkg::RS_DEPTH-1:0] issue_mask;
    int                               issue_idx;
    int                               free_idx;
    logic                             reserve_hit [2];

    always_comb begin
        issue_mask = '0;
        issue_idx  = 0;
        free_idx   = 0;
        for (int i = procyon_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            rs_ready[i] = rs_valid[i] && rs_src_rdy[i][0] && rs_src_rdy[i][1];
            if (!rs_valid[i]) free_idx = i;
        end
        for (int i = 0; i < procyon_pkg::RS_DEPTH; i++) begin
            if (rs_ready[i] && !(|(rs_age[i] & rs_ready))) begin
                issue_mask[i] = 1'b1;
                issue_idx     = i;
            end
        end
        for (int s = 0; s < 2; s++) begin
            reserve_hit[s] = i_cdb_en && !i_src_rdy[s] && (i_src_tag[s] == i_cdb_tag);
        end
    end

    assign o_rs_full = &rs_valid;
    assign fu.valid  = |issue_mask;
    assign fu.op     = rs_op[issue_idx];
    assign fu.src_a  = rs_src_data[issue_idx][0];
    assign fu.src_b  = rs_src_data[issue_idx][1];
    assign fu.tag    = rs_dst_tag[issue_idx];

    always_ff @(posedge clk) begin
        if (i_rst) begin
            rs_valid <= '0;
        end else begin
            if (fu.valid) rs_valid[issue_idx] <= 1'b0;
            if (i_reserve_en) rs_valid[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < procyon_pkg::RS_DEPTH; i++) begin
            rs_age[i] <= rs_age[i] & ~issue_mask;
            for (int s = 0; s < 2; s++) begin
                if (i_cdb_en && !rs_src_rdy[i][s] && (rs_src_tag[i][s] == i_cdb_tag)) begin
                    rs_src_rdy[i][s]  <= 1'b1;
                    rs_src_data[i][s] <= i_cdb_data;
                end
            end
        end

        if (i_reserve_en) begin
            rs_op[free_idx]      <= i_op;
            rs_dst_tag[free_idx] <= i_dst_tag;
            rs_age[free_idx]     <= rs_valid & ~issue_mask;
            for (int s = 0; s < 2; s++) begin
                rs_src_rdy[free_idx][s]  <= i_src_rdy[s] | reserve_hit[s];
                rs_src_data[free_idx][s] <= reserve_hit[s] ? i_cdb_data : i_src_data[s];
                rs_src_tag[free_idx][s]  <= i_src_tag[s];
            end
        end
    end

    a_issue_only_ready: assert property (@(posedge clk) disable iff (i_rst)
        fu.valid |-> rs_valid[issue_idx] && rs_src_rdy[issue_idx][0] && rs_src_rdy[issue_idx][1]);

    // The same tag never goes out twice in a row
    a_no_double_issue: assert property (@(posedge clk) disable iff (i_rst)
        fu.valid |=> !fu.valid || (fu.tag != $past(fu.tag)));

endmodule

// ==== rtl/procyon_ieu.sv ====
//==============================
// Integer execution unit
// Accepts an operation every cycle and drives the CDB one cycle later
//==============================

module procyon_ieu (
    input  logic                  clk,
    input  logic                  i_rst,
    procyon_fu_if.ieu             fu,
    output logic                  o_cdb_en,
    output procyon_pkg::word_t    o_cdb_data,
    output procyon_pkg::rob_tag_t o_cdb_tag
);

    procyon_pkg::word_t result;
    logic [4:0]         shamt;

    assign shamt = fu.src_b[4:0];

    always_comb begin
        case (fu.op)
            procyon_pkg::PCYN_OP_SUB:  result = fu.src_a - fu.src_b;
            procyon_pkg::PCYN_OP_AND:  result = fu.src_a & fu.src_b;
            procyon_pkg::PCYN_OP_OR:   result = fu.src_a | fu.src_b;
            procyon_pkg::PCYN_OP_XOR:  result = fu.src_a ^ fu.src_b;
            procyon_pkg::PCYN_OP_SLL:  result = fu.src_a << shamt;
            procyon_pkg::PCYN_OP_SRL:  result = fu.src_a >> shamt;
            procyon_pkg::PCYN_OP_SRA:  result = $signed(fu.src_a) >>> shamt;
            procyon_pkg::PCYN_OP_SLT:  result = procyon_pkg::word_t'($signed(fu.src_a) < $signed(fu.src_b));
            procyon_pkg::PCYN_OP_SLTU: result = procyon_pkg::word_t'(fu.src_a < fu.src_b);
            default:                   result = fu.src_a + fu.src_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) o_cdb_en <= 1'b0;
        else       o_cdb_en <= fu.valid;
    end

    always_ff @(posedge clk) begin
        o_cdb_data <= result;
        o_cdb_tag  <= fu.tag;
    end

endmodule

// ==== rtl/procyon.sv ====
//==============================
// Out-of-order integer core top level
// Instructions are taken when valid is high and stall is low
// Retire port has no back-pressure
//==============================

module procyon (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_insn_valid,
    input  procyon_pkg::word_t    i_insn,
    output logic                  o_insn_stall,
    output logic                  o_retire_en,
    output procyon_pkg::reg_idx_t o_retire_rdst,
    output procyon_pkg::word_t    o_retire_data
);

    procyon_pkg::reg_idx_t lookup_rsrc      [0:1];
    logic                  rat_lookup_rdy   [0:1];
    procyon_pkg::word_t    rat_lookup_data  [0:1];
    procyon_pkg::rob_tag_t rat_lookup_tag   [0:1];
    logic                  rob_lookup_rdy   [0:1];
    procyon_pkg::word_t    rob_lookup_data  [0:1];
    logic                  dispatch_en;
    procyon_pkg::pcyn_op_t dispatch_op;
    procyon_pkg::reg_idx_t dispatch_rdst;
    logic                  src_rdy          [0:1];
    procyon_pkg::word_t    src_data         [0:1];
    procyon_pkg::rob_tag_t src_tag          [0:1];
    procyon_pkg::rob_tag_t reserve_tag;
    logic                  rob_full;
    logic                  rs_full;
    logic                  cdb_en;
    procyon_pkg::word_t    cdb_data;
    procyon_pkg::rob_tag_t cdb_tag;
    procyon_pkg::rob_tag_t retire_tag;

    procyon_fu_if fu_if ();

    procyon_decode procyon_decode_inst (
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .i_rob_full(rob_full),
        .i_rs_full(rs_full),
        .o_insn_stall(o_insn_stall),
        .o_lookup_rsrc(lookup_rsrc),
        .i_rat_rdy(rat_lookup_rdy),
        .i_rat_data(rat_lookup_data),
        .i_rat_tag(rat_lookup_tag),
        .i_rob_lookup_rdy(rob_lookup_rdy),
        .i_rob_lookup_data(rob_lookup_data),
        .o_dispatch_en(dispatch_en),
        .o_dispatch_op(dispatch_op),
        .o_dispatch_imm(),              // Already folded into source two
        .o_dispatch_rdst(dispatch_rdst),
        .o_src_rdy(src_rdy),
        .o_src_data(src_data),
        .o_src_tag(src_tag)
    );

    procyon_rat procyon_rat_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_lookup_rsrc(lookup_rsrc),
        .o_lookup_rdy(rat_lookup_rdy),
        .o_lookup_data(rat_lookup_data),
        .o_lookup_tag(rat_lookup_tag),
        .i_rename_en(dispatch_en),
        .i_rename_rdst(dispatch_rdst),
        .i_rename_tag(reserve_tag),
        .i_retire_en(o_retire_en),
        .i_retire_rdst(o_retire_rdst),
        .i_retire_data(o_retire_data),
        .i_retire_tag(retire_tag)
    );

    procyon_rob procyon_rob_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_reserve_en(dispatch_en),
        .i_reserve_rdst(dispatch_rdst),
        .o_reserve_tag(reserve_tag),
        .o_rob_full(rob_full),
        .i_lookup_tag(rat_lookup_tag),
        .o_lookup_rdy(rob_lookup_rdy),
        .o_lookup_data(rob_lookup_data),
        .i_cdb_en(cdb_en),
        .i_cdb_data(cdb_data),
        .i_cdb_tag(cdb_tag),
        .o_retire_en(o_retire_en),
        .o_retire_rdst(o_retire_rdst),
        .o_retire_data(o_retire_data),
        .o_retire_tag(retire_tag)
    );

    procyon_rs procyon_rs_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_reserve_en(dispatch_en),
        .i_op(dispatch_op),
        .i_dst_tag(reserve_tag),
        .i_src_rdy(src_rdy),
        .i_src_data(src_data),
        .i_src_tag(src_tag),
        .o_rs_full(rs_full),
        .i_cdb_en(cdb_en),
        .i_cdb_data(cdb_data),
        .i_cdb_tag(cdb_tag),
        .fu(fu_if.rs)
    );

    procyon_ieu procyon_ieu_inst (
        .clk(clk),
        .i_rst(i_rst),
        .fu(fu_if.ieu),
        .o_cdb_en(cdb_en),
        .o_cdb_data(cdb_data),
        .o_cdb_tag(cdb_tag)
    );

endmodule

// ==== testbench/procyon_tb.sv ====
//==============================
// Testbench for the procyon core
// Drives instructions through the valid/stall port and checks
// each retire, in order, against a reference model
// Random programs only use x0 to x7 so dependencies are frequent
//==============================

module procyon_tb;

    localparam int NUM_DIRECTED = 33;
    localparam int NUM_RANDOM   = 200;
    localparam int MAX_CYCLES   = 30 * (NUM_DIRECTED + NUM_RANDOM) + 100;

    logic                  clk;
    logic                  i_rst;
    logic                  i_insn_valid;
    procyon_pkg::word_t    i_insn;
    logic                  o_insn_stall;
    logic                  o_retire_en;
    procyon_pkg::reg_idx_t o_retire_rdst;
    procyon_pkg::word_t    o_retire_data;

    integer      seed;
    int          error_count;
    int          accepted_count;
    int          retired_count;
    int          stall_count;
    int          cycle_count;
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd_q   [$];
    logic [31:0] exp_data_q [$];

    procyon UUT (
        .clk(clk),
        .i_rst(i_rst),
        .i_insn_valid(i_insn_valid),
        .i_insn(i_insn),
        .o_insn_stall(o_insn_stall),
        .o_retire_en(o_retire_en),
        .o_retire_rdst(o_retire_rdst),
        .o_retire_data(o_retire_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // RV32I OP and OP-IMM semantics
    function automatic void ref_exec(input logic [31:0] insn, input logic [31:0] regs [32],
                                     output logic [4:0] rd, output logic [31:0] result);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic        is_imm;
        logic        alt;

        rd     = insn[11:7];
        f3     = insn[14:12];
        is_imm = (insn[6:0] == 7'b0010011);
        a      = (insn[19:15] == 5'd0) ? 32'd0 : regs[insn[19:15]];
        if (is_imm) b = {{20{insn[31]}}, insn[31:20]};
        else        b = (insn[24:20] == 5'd0) ? 32'd0 : regs[insn[24:20]];
        alt    = insn[30] && !(is_imm && f3 == 3'b000);   // ADDI has no subtract form

        case (f3)
            3'b000:  result = alt ? a - b : a + b;
            3'b001:  result = a << b[4:0];
            3'b010:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  result = (a < b) ? 32'd1 : 32'd0;
            3'b100:  result = a ^ b;
            3'b101: begin
                if (alt) result = $signed(a) >>> b[4:0];
                else     result = a >> b[4:0];
            end
            3'b110:  result = a | b;
            default: result = a & b;
        endcase
    endfunction

    function automatic logic [31:0] random_insn();
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] insn;

        f3  = 3'($random(seed));
        rd  = 5'($random(seed) & 7);
        rs1 = 5'($random(seed) & 7);
        rs2 = 5'($random(seed) & 7);
        alt = 1'($random(seed)) && (f3 == 3'b000 || f3 == 3'b101);
        if ($random(seed) & 1) begin
            imm = 12'($random(seed));
            if (f3 == 3'b001) imm[11:5] = 7'h00;
            if (f3 == 3'b101) imm[11:5] = alt ? 7'h20 : 7'h00;
            insn = enc_i(imm, rs1, f3, rd);
        end else begin
            insn = enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
        end
        return insn;
    endfunction

    // Holds the instruction until the stall drops so the next edge takes it
    task automatic send_insn(input logic [31:0] insn);
        logic [4:0]  rd;
        logic [31:0] result;

        @(posedge clk);
        i_insn_valid <= 1'b1;
        i_insn       <= insn;
        @(negedge clk);
        while (o_insn_stall) begin
            stall_count++;
            @(negedge clk);
        end
        ref_exec(insn, model_regs, rd, result);
        if (rd != 5'd0) model_regs[rd] = result;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
        accepted_count++;
    endtask

    task automatic drain();
        @(posedge clk);
        i_insn_valid <= 1'b0;
        while (exp_rd_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (!i_rst && o_retire_en) begin
            retired_count++;
            assert (exp_rd_q.size() != 0) else begin
                error_count++;
                $display("unexpected retire at time %0t with nothing outstanding", $time);
            end
            if (exp_rd_q.size() != 0) begin
                assert (o_retire_rdst == exp_rd_q[0]) else begin
                    error_count++;
                    $display("mismatch at %0t: o_retire_rdst got %0d expected %0d",
                             $time, o_retire_rdst, exp_rd_q[0]);
                end
                assert (o_retire_data == exp_data_q[0]) else begin
                    error_count++;
                    $display("mismatch at %0t: o_retire_data got %h expected %h",
                             $time, o_retire_data, exp_data_q[0]);
                end
                void'(exp_rd_q.pop_front());
                void'(exp_data_q.pop_front());
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d of %0d accepted instructions retired",
                 cycle_count, retired_count, accepted_count);
        $display("errors: %0d", error_count + 1);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        i_rst          = 1'b1;
        i_insn_valid   = 1'b0;
        i_insn         = '0;
        seed           = 32'hfbb7;
        error_count    = 0;
        accepted_count = 0;
        retired_count  = 0;
        stall_count    = 0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;

        // Idle core must not retire
        repeat (10) begin
            @(negedge clk);
            assert (!o_retire_en) else begin
                error_count++;
                $display("retire seen at time %0t with no instruction sent", $time);
            end
        end

        // Every operation with sources committed in the RAT
        send_insn(enc_i(12'hed4, 5'd0, 3'b000, 5'd1));
        send_insn(enc_i(12'd37, 5'd0, 3'b000, 5'd2));
        drain();
        for (int f3 = 0; f3 < 8; f3++) send_insn(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'(10 + f3)));
        send_insn(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd18));
        send_insn(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd19));
        for (int f3 = 0; f3 < 8; f3++) begin
            send_insn(enc_i((f3 == 1 || f3 == 5) ? 12'd7 : 12'h5a3, 5'd1, 3'(f3), 5'(20 + f3)));
        end
        send_insn(enc_i(12'h407, 5'd1, 3'b101, 5'd28));   // SRAI
        drain();

        // Back-to-back chain with sources from the RAT, the ROB and the CDB
        send_insn(enc_i(12'd5, 5'd0, 3'b000, 5'd1));
        send_insn(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        send_insn(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));   // x1 caught off the CDB
        send_insn(enc_r(7'h00, 5'd2, 5'd3, 3'b100, 5'd4));
        send_insn(enc_r(7'h00, 5'd1, 5'd4, 3'b001, 5'd5));   // x1 already committed
        send_insn(enc_r(7'h20, 5'd2, 5'd5, 3'b101, 5'd6));   // x2 done but not yet retired
        send_insn(enc_r(7'h00, 5'd4, 5'd6, 3'b010, 5'd7));
        send_insn(enc_r(7'h00, 5'd5, 5'd7, 3'b110, 5'd1));
        drain();

        repeat (NUM_RANDOM) send_insn(random_insn());
        drain();

        // Writes to x0 retire their data but never reach later readers
        send_insn(enc_i(12'd77, 5'd0, 3'b000, 5'd0));
        send_insn(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd5));
        send_insn(enc_i(12'd3, 5'd0, 3'b000, 5'd6));
        send_insn(enc_r(7'h20, 5'd6, 5'd0, 3'b000, 5'd7));
        drain();

        assert (exp_rd_q.size() == 0) else begin
            error_count++;
            $display("%0d expected retires never arrived", exp_rd_q.size());
        end
        assert (retired_count == accepted_count) else begin
            error_count++;
            $display("retired %0d instructions but %0d were accepted",
                     retired_count, accepted_count);
        end
        assert (stall_count > 0) else begin
            error_count++;
            $display("o_insn_stall was never seen high");
        end

        $display("errors: %0d, accepted: %0d, retired: %0d, stall cycles: %0d",
                 error_count, accepted_count, retired_count, stall_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rtl/procyon_pkg.sv
rtl/procyon_fu_if.sv
rtl/procyon_decode.sv
rtl/procyon_rat.sv
rtl/procyon_rob.sv
rtl/procyon_rs.sv
rtl/procyon_ieu.sv
rtl/procyon.sv
testbench/procyon_tb.sv

// ==== Bender.yml ====
package:
  name: procyon

sources:
  - rtl/procyon_pkg.sv
  - rtl/procyon_fu_if.sv
  - rtl/procyon_decode.sv
  - rtl/procyon_rat.sv
  - rtl/procyon_rob.sv
  - rtl/procyon_rs.sv
  - rtl/procyon_ieu.sv
  - rtl/procyon.sv
  - target: test
    files:
      - testbench/procyon_tb.sv
